// File: armPkg.sv
package armPkg;

  // instruction class, instr[27:26]
  typedef enum logic [1:0] {
    opDataProc = 2'b00,
    opMemory   = 2'b01,
    opBranch   = 2'b10
  } opT;

  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluSub = 3'b001,
    aluAnd = 3'b010,
    aluOrr = 3'b011,
    aluAdc = 3'b100
  } aluCtrlT;

  // condition field, instr[31:28]
  typedef enum logic [3:0] {
    eq = 4'b0000,
    ne = 4'b0001,
    cs = 4'b0010,
    cc = 4'b0011,
    mi = 4'b0100,
    pl = 4'b0101,
    vs = 4'b0110,
    vc = 4'b0111,
    hi = 4'b1000,
    ls = 4'b1001,
    ge = 4'b1010,
    lt = 4'b1011,
    gt = 4'b1100,
    le = 4'b1101,
    al = 4'b1110
  } condT;

  typedef struct packed {
    logic    n;
    logic    z;
    logic    c;
    logic    v;
  } flagsT;

  typedef struct packed {
    logic [1:0] regSrc;    // [0] ra1 = r15, [1] ra2 = rd
    logic [1:0] immSrc;    // 8-bit, 12-bit, branch offset
    logic       aluSrc;
    logic       memToReg;
    logic       regW;
    logic       memW;
    logic       branch;
    aluCtrlT    aluCtrl;
    logic [1:0] flagW;     // [1] nz, [0] cv
    logic       noWrite;   // tst, cmn
    logic       shift;     // lsl
    logic       pcs;       // writes r15
  } decodeT;

endpackage

// File: decoder.sv
`timescale 1ns/1ps

module decoder import armPkg::*; (
  input  opT         op,
  input  logic [5:0] funct,
  input  logic [3:0] rd,
  output decodeT     decode
);

  logic aluOp;   // data-processing instruction
  logic arith;   // op updates c and v

  // main decoder
  always_comb begin
    decode.regSrc   = 2'b00;
    decode.immSrc   = 2'b00;
    decode.aluSrc   = 1'b0;
    decode.memToReg = 1'b0;
    decode.regW     = 1'b0;
    decode.memW     = 1'b0;
    decode.branch   = 1'b0;
    aluOp           = 1'b0;
    case (op)
      opDataProc: begin
        decode.aluSrc = funct[5];   // immediate bit
        decode.regW   = 1'b1;
        aluOp         = 1'b1;
      end
      opMemory: begin
        decode.immSrc = 2'b01;
        decode.aluSrc = 1'b1;
        if (funct[0]) begin          // ldr
          decode.memToReg = 1'b1;
          decode.regW     = 1'b1;
        end else begin               // str
          decode.regSrc = 2'b10;
          decode.memW   = 1'b1;
        end
      end
      opBranch: begin
        decode.regSrc = 2'b01;
        decode.immSrc = 2'b10;
        decode.aluSrc = 1'b1;
        decode.branch = 1'b1;
      end
      default: ;                     // reserved class does nothing
    endcase
  end

  // alu decoder
  always_comb begin
    decode.aluCtrl = aluAdd;         // address and target adds
    decode.noWrite = 1'b0;
    decode.shift   = 1'b0;
    arith          = 1'b0;
    if (aluOp) begin
      case (funct[4:1])
        4'b0100: arith = 1'b1;                        // add
        4'b0010: begin                                // sub
          decode.aluCtrl = aluSub;
          arith          = 1'b1;
        end
        4'b0000: decode.aluCtrl = aluAnd;             // and
        4'b1100: decode.aluCtrl = aluOrr;             // orr
        4'b1000: begin                                // tst
          decode.aluCtrl = aluAnd;
          decode.noWrite = 1'b1;
        end
        4'b1101: decode.shift = 1'b1;                 // lsl
        4'b1011: begin                                // cmn
          decode.noWrite = 1'b1;
          arith          = 1'b1;
        end
        4'b0101: begin                                // adc
          decode.aluCtrl = aluAdc;
          arith          = 1'b1;
        end
        default: decode.noWrite = 1'b1;               // undecoded, acts as nop
      endcase
    end
  end

  // s bit drives the flag mask, undecoded funct never sets flags
  assign decode.flagW[1] = aluOp & funct[0] & ~(decode.noWrite & ~arith & ~decode.shift &
                           decode.aluCtrl == aluAdd);
  assign decode.flagW[0] = aluOp & funct[0] & arith;

  // pc written by a dp or load to r15, or by a branch
  assign decode.pcs = ((rd == 4'd15) & decode.regW & ~decode.noWrite) | decode.branch;

endmodule

// File: condLogic.sv
`timescale 1ns/1ps

module condLogic import armPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  decodeT decode,
  input  condT   cond,
  input  flagsT  aluFlags,
  output logic   pcSrc,
  output logic   regWrite,
  output logic   memWrite,
  output logic   carry
);

  flagsT flags;      // stored nzcv
  logic  condEx;     // condition passes
  logic  condPass;

  always_comb begin
    case (cond)
      eq:      condEx = flags.z;
      ne:      condEx = ~flags.z;
      cs:      condEx = flags.c;
      cc:      condEx = ~flags.c;
      mi:      condEx = flags.n;
      pl:      condEx = ~flags.n;
      vs:      condEx = flags.v;
      vc:      condEx = ~flags.v;
      hi:      condEx = flags.c & ~flags.z;
      ls:      condEx = ~flags.c | flags.z;
      ge:      condEx = (flags.n == flags.v);
      lt:      condEx = (flags.n != flags.v);
      gt:      condEx = ~flags.z & (flags.n == flags.v);
      le:      condEx = flags.z | (flags.n != flags.v);
      al:      condEx = 1'b1;
      default: condEx = 1'b0;        // 4'b1111 never executes
    endcase
  end

  // no architectural writes while in reset
  assign condPass = condEx & rstN;

  // nz and cv halves update separately
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      if (decode.flagW[1] & condEx) begin
        flags.n <= aluFlags.n;
        flags.z <= aluFlags.z;
      end
      if (decode.flagW[0] & condEx) begin
        flags.c <= aluFlags.c;
        flags.v <= aluFlags.v;
      end
    end
  end

  assign pcSrc    = decode.pcs & condPass;
  assign regWrite = decode.regW & condPass & ~decode.noWrite;
  assign memWrite = decode.memW & condPass;
  assign carry    = flags.c;   // for adc

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa3,
  input  logic [31:0] wd3,
  input  logic        we3,
  input  logic [31:0] r15,   // pc + 8
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] rf [0:14];    // r0..r14, r15 lives in the pc

  always_ff @(posedge clk) begin
    if (we3 && wa3 != 4'd15) begin
      rf[wa3] <= wd3;
    end
  end

  assign rd1 = (ra1 == 4'd15) ? r15 : rf[ra1];
  assign rd2 = (ra2 == 4'd15) ? r15 : rf[ra2];

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu import armPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluCtrlT     aluCtrl,
  input  logic        carryIn,
  output logic [31:0] result,
  output flagsT       flags
);

  logic [31:0] bIn;     // b or its inverse for sub
  logic        cIn;
  logic [32:0] sum;     // carry out in bit 32
  logic        isArith;

  assign bIn = (aluCtrl == aluSub) ? ~b : b;

  always_comb begin
    case (aluCtrl)
      aluSub:  cIn = 1'b1;
      aluAdc:  cIn = carryIn;
      default: cIn = 1'b0;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, bIn} + {32'b0, cIn};

  always_comb begin
    case (aluCtrl)
      aluAnd:  result = a & b;
      aluOrr:  result = a | b;
      default: result = sum[31:0];   // add, sub, adc
    endcase
  end

  assign isArith = (aluCtrl == aluAdd) | (aluCtrl == aluSub) | (aluCtrl == aluAdc);

  assign flags.n = result[31];
  assign flags.z = (result == 32'b0);
  assign flags.c = isArith & sum[32];
  // signed overflow when operands agree in sign and the sum does not
  assign flags.v = isArith & (a[31] == bIn[31]) & (sum[31] != a[31]);

endmodule

// File: datapath.sv
`timescale 1ns/1ps

module datapath import armPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  decodeT      decode,
  input  logic        pcSrc,
  input  logic        regWrite,
  input  logic        carry,
  input  logic [31:0] instr,
  input  logic [31:0] readData,
  output logic [31:0] pc,
  output logic [31:0] aluResult,
  output logic [31:0] writeData,
  output flagsT       aluFlags
);

  logic [31:0] pcPlus4, pcPlus8, pcNext;
  logic [3:0]  ra1, ra2;
  logic [31:0] rd1, rd2;
  logic [31:0] extImm;
  logic [31:0] shifted;       // rm << shamt
  logic [31:0] srcA, srcB;
  logic [31:0] result;

  assign pcPlus4 = pc + 32'd4;
  assign pcPlus8 = pcPlus4 + 32'd4;
  assign pcNext  = pcSrc ? result : pcPlus4;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  assign ra1 = decode.regSrc[0] ? 4'd15 : instr[19:16];
  assign ra2 = decode.regSrc[1] ? instr[15:12] : instr[3:0];   // str reads rd

  regFile u_regFile (
    .clk (clk),
    .ra1 (ra1),
    .ra2 (ra2),
    .wa3 (instr[15:12]),
    .wd3 (result),
    .we3 (regWrite),
    .r15 (pcPlus8),
    .rd1 (rd1),
    .rd2 (rd2)
  );

  always_comb begin
    case (decode.immSrc)
      2'b00:   extImm = {24'b0, instr[7:0]};                       // dp immediate
      2'b01:   extImm = {20'b0, instr[11:0]};                      // ldr/str offset
      2'b10:   extImm = {{6{instr[23]}}, instr[23:0], 2'b00};      // branch words
      default: extImm = 32'b0;
    endcase
  end

  assign shifted = rd2 << instr[11:7];
  assign srcA    = decode.shift ? 32'b0 : rd1;   // lsl ignores rn
  assign srcB    = decode.aluSrc ? extImm : (decode.shift ? shifted : rd2);

  alu u_alu (
    .a       (srcA),
    .b       (srcB),
    .aluCtrl (decode.aluCtrl),
    .carryIn (carry),
    .result  (aluResult),
    .flags   (aluFlags)
  );

  assign result    = decode.memToReg ? readData : aluResult;
  assign writeData = rd2;

endmodule

// File: instrMem.sv
`timescale 1ns/1ps

module instrMem #(
  parameter int imemWords = 64
) (
  input  logic [31:0] addr,
  output logic [31:0] rdata
);

  localparam int addrBits = $clog2(imemWords);

  logic [31:0] mem [0:imemWords-1];

  initial begin
    $readmemh("program.hex", mem);
  end

  assign rdata = mem[addr[addrBits+1:2]];   // word index

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem #(
  parameter int dmemWords = 64
) (
  input  logic        clk,
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  localparam int addrBits = $clog2(dmemWords);

  logic [31:0]         mem [0:dmemWords-1];
  logic [addrBits-1:0] wordIdx;

  assign wordIdx = addr[addrBits+1:2];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wordIdx] <= wdata;
    end
  end

  assign rdata = mem[wordIdx];   // async read for ldr

endmodule

// File: armTop.sv
`timescale 1ns/1ps

module armTop import armPkg::*; #(
  parameter int imemWords = 64,
  parameter int dmemWords = 64
) (
  input  logic        clk,
  input  logic        rstN,
  output logic [31:0] pc,
  output logic        memWrite,
  output logic [31:0] dataAdr,
  output logic [31:0] writeData
);

  logic [31:0] instr;
  logic [31:0] readData;
  decodeT      decode;
  flagsT       aluFlags;
  logic        pcSrc;
  logic        regWrite;
  logic        carry;

  instrMem #(.imemWords(imemWords)) u_instrMem (
    .addr  (pc),
    .rdata (instr)
  );

  decoder u_decoder (
    .op     (opT'(instr[27:26])),
    .funct  (instr[25:20]),
    .rd     (instr[15:12]),
    .decode (decode)
  );

  condLogic u_condLogic (
    .clk      (clk),
    .rstN     (rstN),
    .decode   (decode),
    .cond     (condT'(instr[31:28])),
    .aluFlags (aluFlags),
    .pcSrc    (pcSrc),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .carry    (carry)
  );

  datapath u_datapath (
    .clk       (clk),
    .rstN      (rstN),
    .decode    (decode),
    .pcSrc     (pcSrc),
    .regWrite  (regWrite),
    .carry     (carry),
    .instr     (instr),
    .readData  (readData),
    .pc        (pc),
    .aluResult (dataAdr),
    .writeData (writeData),
    .aluFlags  (aluFlags)
  );

  dataMem #(.dmemWords(dmemWords)) u_dataMem (
    .clk   (clk),
    .we    (memWrite),
    .addr  (dataAdr),
    .wdata (writeData),
    .rdata (readData)
  );

endmodule

// File: armTb_assertions.sv
`timescale 1ns/1ps

module armTb_assertions (
  input logic        clk,
  input logic        rstN,
  input logic [31:0] pc,
  input logic        memWrite
);

  int failCount = 0;   // failed assertions so far

  noStoreInReset: assert property (@(posedge clk) !rstN |-> !memWrite)
    else begin
      $error("memWrite is high while reset is asserted");
      failCount++;
    end

  // first fetch after reset comes from address 0
  firstPcZero: assert property (@(posedge clk) $rose(rstN) |-> pc == 32'd0)
    else begin
      $error("pc is not zero in the first cycle after reset");
      failCount++;
    end

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else begin
      $error("pc is not word-aligned");
      failCount++;
    end

  pcKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(pc))
    else begin
      $error("pc holds an unknown value");
      failCount++;
    end

endmodule

// File: armTb.sv
`timescale 1ns/1ps

module armTb;

  localparam int clkPeriod   = 8;
  localparam int resetCycles = 16;
  localparam int progWords   = 48;   // words in program.hex
  localparam int limitCycles = resetCycles + progWords + 200;
  localparam logic [31:0] lastAdr = 32'd252;   // final store marks the end

  logic        clk  = 1'b0;
  logic        rstN = 1'b0;
  logic [31:0] pc;
  logic        memWrite;
  logic [31:0] dataAdr;
  logic [31:0] writeData;

  logic [31:0] expAdr[$];
  logic [31:0] expData[$];
  int          storeIdx = 0;
  int          errors   = 0;
  logic        done     = 1'b0;

  armTop u_armTop (
    .clk       (clk),
    .rstN      (rstN),
    .pc        (pc),
    .memWrite  (memWrite),
    .dataAdr   (dataAdr),
    .writeData (writeData)
  );

  bind armTop armTb_assertions u_assertions (
    .clk      (clk),
    .rstN     (rstN),
    .pc       (pc),
    .memWrite (memWrite)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic expectStore(input logic [31:0] adr, input logic [31:0] data);
    expAdr.push_back(adr);
    expData.push_back(data);
  endtask

  // every store is compared with the next table entry
  always @(posedge clk) begin
    if (rstN && memWrite && !done) begin
      if (storeIdx >= expAdr.size()) begin
        $display("Unexpected extra store to address 0x%08h at %0d ns", dataAdr, $time);
        errors++;
      end else begin
        assert (dataAdr == expAdr[storeIdx] && writeData == expData[storeIdx])
        else begin
          $display("[FAIL] %0d ns: store %0d wrote 0x%08h to 0x%08h, expected 0x%08h to 0x%08h",
                   $time, storeIdx, writeData, dataAdr, expData[storeIdx], expAdr[storeIdx]);
          errors++;
        end
      end
      storeIdx++;
      if (dataAdr == lastAdr) begin
        done = 1'b1;
      end
    end
  end

  initial begin
    expectStore(32'h40, 32'd17);         // add 5 + 12
    expectStore(32'h44, 32'd9);          // sub 12 - 3
    expectStore(32'h48, 32'd1);          // and 17, 9
    expectStore(32'h4C, 32'hF5);         // orr 5, 0xf0
    expectStore(32'h50, 32'hC0);         // lsl 12 by 4
    expectStore(32'h54, 32'd12);         // strne, tst leaves z clear
    expectStore(32'h58, 32'd9);          // streq, tst sets z
    expectStore(32'h5C, 32'd5);          // strmi, cmn result negative
    expectStore(32'h60, 32'd0);          // strcs, adds wraps with carry
    expectStore(32'h64, 32'd18);         // adc 5 + 12 + carry
    expectStore(32'h68, 32'hFFFFFFF9);   // strlt, subs 5 - 12
    expectStore(32'h40, 32'd18);         // ldr of first store, plus one
    expectStore(32'h74, 32'd12);         // bne not taken
    expectStore(32'h7C, 32'hF5);         // target of add into r15
    expectStore(lastAdr, 32'd17);

    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;

    wait (done);
    if (storeIdx != expAdr.size()) begin
      $display("Program ended after %0d stores instead of %0d", storeIdx, expAdr.size());
      errors++;
    end
    if (u_armTop.u_assertions.failCount != 0) begin
      $display("%0d concurrent assertions failed", u_armTop.u_assertions.failCount);
      errors += u_armTop.u_assertions.failCount;
    end
    $display("Stores checked: %0d of %0d, errors: %0d", storeIdx, expAdr.size(), errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog for a program that never reaches its last store
  initial begin
    #(limitCycles * clkPeriod);
    $display("Timeout: the program never finished within %0d cycles, %0d stores seen, %0d errors",
             limitCycles, storeIdx, errors);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: program.hex
// columns: eight 32-bit instruction words per line, in hexadecimal
// the first word sits at byte address 0x00, each following word 4 bytes higher
E3A00000 E3A01005 E3A0200C E0813002 E5803040 E2424003 E5804044 E0035004 // 0x00 mov add sub and
E38160F0 E5805048 E580604C E1A07202 E5807050 E1130004 05801054 15802054 // 0x20 orr lsl tst
E3110002 05804058 15805058 E3A080FF E1A08C08 E1780001 4580105C 5580205C // 0x40 tst cmn
E3A0A001 E1A0AC0A E098B00A 2580B060 85801060 E0A1C002 E580C064 E051D002 // 0x60 adds adc subs
B580D068 A5801068 E590E040 E28EE001 E580E040 E2519005 0A000000 E5801074 // 0x80 ldr beq
1A000002 E5802074 E28FF004 E5801078 E5804078 E580607C E58030FC EAFFFFFE // 0xa0 bne pc jump end

// File: src.f
armPkg.sv
decoder.sv
condLogic.sv
regFile.sv
alu.sv
datapath.sv
instrMem.sv
dataMem.sv
armTop.sv
armTb_assertions.sv
armTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= armTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
